// ==== lsu_subsys.f ====
hdl/axi_pkg.sv
hdl/lsu_pkg.sv
hdl/lsu.sv
hdl/axi_lite_decoder.sv
hdl/axi_lite_sram.sv
hdl/axi_lite_console.sv
hdl/lsu_subsys.sv
dv/lsu_subsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_subsys_tb
FILELIST  ?= lsu_subsys.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) \
	  --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/lsu_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_subsys_tb;

  import axi_pkg::*;
  import lsu_pkg::*;

  localparam int sram_words        = 256;
  localparam int sram_read_latency = 3;
  localparam int model_aw          = $clog2(4 * sram_words);
  localparam int done_timeout      = 200;

  logic         clock;
  logic         reset;
  logic         ren;
  logic         wen;
  logic [31:0]  addr;
  access_size_t size;
  logic         sign_extend;
  logic [31:0]  store_data;
  logic [31:0]  load_data;
  logic         read_done;
  logic         write_done;
  resp_t        resp;
  logic [7:0]   char_data;
  logic         char_valid;

  logic [7:0]   model [4 * sram_words];   // byte image of the sram.
  logic [7:0]   char_expect [$];
  int           chars_sent;
  integer       seed;

  lsu_subsys #(
    .sram_words        (sram_words),
    .sram_read_latency (sram_read_latency)
  ) i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input resp_t actual, input resp_t expected);
    if (actual !== expected) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
      abort_run();
    end
  endtask

  // console characters arrive in the order they were stored.
  always @(negedge clock) begin
    if (!reset && char_valid) begin
      if (char_expect.size() == 0) begin
        $display("console printed a character that was never written");
        abort_run();
      end else begin
        check_data("char_data", {24'h0, char_data}, {24'h0, char_expect.pop_front()});
      end
    end
  end

  function automatic logic [7:0] model_byte(input logic [31:0] a);
    logic [31:0] diff;
    diff = a - sram_base;
    return model[diff[model_aw-1:0]];
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] a, input access_size_t s,
                                                input logic sx);
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    b0 = model_byte(a);
    b1 = model_byte(a + 32'd1);
    b2 = model_byte(a + 32'd2);
    b3 = model_byte(a + 32'd3);
    case (s)
      size_byte: return {{24{sx & b0[7]}}, b0};
      size_half: return {{16{sx & b1[7]}}, b1, b0};
      default:   return {b3, b2, b1, b0};
    endcase
  endfunction

  task automatic model_store(input logic [31:0] a, input access_size_t s,
                             input logic [31:0] d);
    int          n;
    logic [31:0] diff;
    case (s)
      size_byte: n = 1;
      size_half: n = 2;
      default:   n = 4;
    endcase
    for (int i = 0; i < n; i++) begin
      diff = a - sram_base + i;
      model[diff[model_aw-1:0]] = d[8*i +: 8];
    end
  endtask

  // one request pulse, then wait for the matching done pulse.
  task automatic access(input logic rd, input logic [31:0] a, input access_size_t s,
                        input logic sx, input logic [31:0] d);
    int cycles;
    @(posedge clock);
    ren         <= rd;
    wen         <= !rd;
    addr        <= a;
    size        <= s;
    sign_extend <= sx;
    store_data  <= d;
    @(posedge clock);
    ren <= 1'b0;
    wen <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      if (cycles > done_timeout) begin
        $display("timeout: no done pulse within %0d cycles at address 0x%08h",
                 done_timeout, a);
        abort_run();
      end
    end while (!(read_done || write_done));
    if (read_done != rd || write_done != !rd) begin
      $display("the wrong done pulse came back for the access at 0x%08h", a);
      abort_run();
    end
  endtask

  task automatic store_checked(input logic [31:0] a, input access_size_t s,
                               input logic [31:0] d, input resp_t exp_resp);
    access(1'b0, a, s, 1'b0, d);
    check_resp("resp", resp, exp_resp);
    if (exp_resp == resp_okay && a[31:28] == sram_base[31:28]) begin
      model_store(a, s, d);
    end
  endtask

  task automatic load_checked(input logic [31:0] a, input access_size_t s, input logic sx,
                              input logic [31:0] exp_data, input resp_t exp_resp);
    access(1'b1, a, s, sx, 32'h0);
    check_resp("resp", resp, exp_resp);
    check_data("load_data", load_data, exp_data);
  endtask

  task automatic fill_sram();
    logic [31:0] a;
    for (int k = 0; k < sram_words; k++) begin
      a = sram_base + 4 * k;
      store_checked(a, size_word, (a * 32'h0101_0107) ^ 32'h5a5a_c3c3, resp_okay);
    end
  endtask

  task automatic word_roundtrip();
    logic [31:0] addrs [4];
    logic [31:0] words [4];
    addrs = '{32'h8000_0000, 32'h8000_0004, 32'h8000_0100, 32'h8000_03fc};
    words = '{32'hdead_beef, 32'h0123_4567, 32'h8000_0001, 32'hffff_0000};
    for (int i = 0; i < 4; i++) begin
      store_checked(addrs[i], size_word, words[i], resp_okay);
      load_checked(addrs[i], size_word, 1'b0, words[i], resp_okay);
    end
  endtask

  task automatic lane_offsets();
    logic [31:0] base;
    logic [31:0] lane_bytes;
    logic [31:0] halves;
    base       = sram_base + 32'h40;
    lane_bytes = 32'h44f3_1281;   // mix of set and clear top bits.
    halves     = 32'h7def_9abc;
    store_checked(base, size_word, 32'h1122_3344, resp_okay);
    for (int off = 0; off < 4; off++) begin
      store_checked(base + off, size_byte, {24'hc3c3c3, lane_bytes[8*off +: 8]}, resp_okay);
      load_checked(base, size_word, 1'b0, expected_load(base, size_word, 1'b0), resp_okay);
    end
    for (int off = 0; off < 4; off += 2) begin
      store_checked(base + off, size_half, {16'hface, halves[8*off +: 16]}, resp_okay);
      load_checked(base, size_word, 1'b0, expected_load(base, size_word, 1'b0), resp_okay);
    end
    for (int sx = 0; sx < 2; sx++) begin
      for (int off = 0; off < 4; off++) begin
        load_checked(base + off, size_byte, sx[0], expected_load(base + off, size_byte, sx[0]),
                     resp_okay);
      end
      for (int off = 0; off < 4; off += 2) begin
        load_checked(base + off, size_half, sx[0], expected_load(base + off, size_half, sx[0]),
                     resp_okay);
      end
      load_checked(base, size_word, sx[0], expected_load(base, size_word, sx[0]), resp_okay);
    end
  endtask

  task automatic console_output();
    logic [31:0] console_addr;
    logic [7:0]  text [4];
    console_addr = {console_page, 12'h000};
    text         = '{8'h52, 8'h56, 8'h33, 8'h32};
    for (int i = 0; i < 4; i++) begin
      char_expect.push_back(text[i]);
      chars_sent++;
      store_checked(console_addr, size_byte, {24'h00a55a, text[i]}, resp_okay);
    end
    if (char_expect.size() != 0) begin
      $display("console printed fewer characters than were written");
      abort_run();
    end
    load_checked(console_addr, size_word, 1'b0, chars_sent, resp_okay);
  endtask

  task automatic error_responses();
    logic [31:0] unmapped;
    logic [31:0] past_end;
    unmapped = 32'h4000_0100;
    past_end = sram_base + 4 * sram_words;
    load_checked(unmapped, size_word, 1'b0, 32'h0, resp_decerr);
    store_checked(unmapped, size_word, 32'hbad0_0001, resp_decerr);
    store_checked(past_end, size_word, 32'hbad0_0002, resp_slverr);
    // the low index bits of past_end alias word 0.
    load_checked(sram_base, size_word, 1'b0, expected_load(sram_base, size_word, 1'b0),
                 resp_okay);
    load_checked(past_end, size_word, 1'b0, 32'h0, resp_slverr);
  endtask

  task automatic random_accesses();
    logic [31:0]  r;
    logic [31:0]  d;
    logic [31:0]  a;
    access_size_t s;
    logic         sx;
    for (int n = 0; n < 64; n++) begin
      r  = $random(seed);
      d  = $random(seed);
      sx = r[4];
      case (r[1:0])
        2'd0:    s = size_byte;
        2'd1:    s = size_half;
        default: s = size_word;
      endcase
      a = sram_base + (r[31:10] % sram_words) * 4;
      if (s == size_byte) begin
        a = a + {30'h0, r[9:8]};
      end else if (s == size_half) begin
        a = a + {30'h0, r[9], 1'b0};
      end
      if (r[20]) begin
        store_checked(a, s, d, resp_okay);
      end else begin
        load_checked(a, s, sx, expected_load(a, s, sx), resp_okay);
      end
    end
  endtask

  initial begin
    reset       = 1'b1;
    ren         = 1'b0;
    wen         = 1'b0;
    addr        = 32'h0;
    size        = size_word;
    sign_extend = 1'b0;
    store_data  = 32'h0;
    chars_sent  = 0;
    seed        = 32'h75a1e618;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    fill_sram();   // every word defined before any load.
    word_roundtrip();
    lane_offsets();
    console_output();
    error_responses();
    random_accesses();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_subsys #(
  parameter int sram_words        = 256,
  parameter int sram_read_latency = 2
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  ren,
  input  logic                  wen,
  input  logic [31:0]           addr,
  input  lsu_pkg::access_size_t size,
  input  logic                  sign_extend,
  input  logic [31:0]           store_data,
  output logic [31:0]           load_data,
  output logic                  read_done,
  output logic                  write_done,
  output axi_pkg::resp_t        resp,
  output logic [7:0]            char_data,
  output logic                  char_valid
);

  import axi_pkg::*;

  // unit to decoder.
  logic [31:0]             araddr, awaddr;
  logic                    arvalid, arready, rvalid, rready;
  logic                    awvalid, awready, wvalid, wready, bvalid, bready;
  logic [data_width-1:0]   rdata, wdata;
  logic [data_width/8-1:0] wstrb;
  resp_t                   rresp, bresp;

  // decoder to sram.
  logic [31:0]             sram_araddr, sram_awaddr;
  logic                    sram_arvalid, sram_arready, sram_rvalid, sram_rready;
  logic                    sram_awvalid, sram_awready, sram_wvalid, sram_wready;
  logic                    sram_bvalid, sram_bready;
  logic [data_width-1:0]   sram_rdata, sram_wdata;
  logic [data_width/8-1:0] sram_wstrb;
  resp_t                   sram_rresp, sram_bresp;

  // decoder to console.
  logic                    console_arvalid, console_arready, console_rvalid, console_rready;
  logic                    console_awvalid, console_awready, console_wvalid, console_wready;
  logic                    console_bvalid, console_bready;
  logic [data_width-1:0]   console_rdata, console_wdata;
  logic [data_width/8-1:0] console_wstrb;
  resp_t                   console_rresp, console_bresp;

  lsu i_lsu (.*);

  axi_lite_decoder i_decoder (.*);

  axi_lite_sram #(
    .sram_words        (sram_words),
    .sram_read_latency (sram_read_latency)
  ) i_sram (
    .clock   (clock),
    .reset   (reset),
    .araddr  (sram_araddr),
    .arvalid (sram_arvalid),
    .arready (sram_arready),
    .rdata   (sram_rdata),
    .rresp   (sram_rresp),
    .rvalid  (sram_rvalid),
    .rready  (sram_rready),
    .awaddr  (sram_awaddr),
    .awvalid (sram_awvalid),
    .awready (sram_awready),
    .wdata   (sram_wdata),
    .wstrb   (sram_wstrb),
    .wvalid  (sram_wvalid),
    .wready  (sram_wready),
    .bresp   (sram_bresp),
    .bvalid  (sram_bvalid),
    .bready  (sram_bready)
  );

  axi_lite_console i_console (
    .clock      (clock),
    .reset      (reset),
    .arvalid    (console_arvalid),
    .arready    (console_arready),
    .rdata      (console_rdata),
    .rresp      (console_rresp),
    .rvalid     (console_rvalid),
    .rready     (console_rready),
    .awvalid    (console_awvalid),
    .awready    (console_awready),
    .wdata      (console_wdata),
    .wstrb      (console_wstrb),
    .wvalid     (console_wvalid),
    .wready     (console_wready),
    .bresp      (console_bresp),
    .bvalid     (console_bvalid),
    .bready     (console_bready),
    .char_data  (char_data),
    .char_valid (char_valid)
  );

endmodule

`default_nettype wire

// ==== hdl/axi_lite_console.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_console (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [axi_pkg::data_width-1:0]     rdata,
  output axi_pkg::resp_t                     rresp,
  output logic                               rvalid,
  input  logic                               rready,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [axi_pkg::data_width-1:0]     wdata,
  input  logic [axi_pkg::data_width/8-1:0]   wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  output axi_pkg::resp_t                     bresp,
  output logic                               bvalid,
  input  logic                               bready,
  output logic [7:0]                         char_data,
  output logic                               char_valid
);

  import axi_pkg::*;

  logic                  aw_taken;
  logic [data_width-1:0] char_count;

  assign arready = arvalid && !rvalid;
  assign awready = awvalid && !aw_taken && !bvalid;
  assign wready  = wvalid && aw_taken;
  assign rresp   = resp_okay;
  assign bresp   = resp_okay;

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid     <= 1'b0;
      bvalid     <= 1'b0;
      aw_taken   <= 1'b0;
      char_valid <= 1'b0;
      char_count <= '0;
    end else begin
      char_valid <= 1'b0;
      if (arvalid && arready) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
      if (awvalid && awready) aw_taken <= 1'b1;
      if (wvalid && wready) begin
        aw_taken <= 1'b0;
        bvalid   <= 1'b1;
        if (wstrb[0]) begin   // only lane 0 prints.
          char_valid <= 1'b1;
          char_count <= char_count + 1'b1;
        end
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (arvalid && arready) rdata <= char_count;
    if (wvalid && wready) char_data <= wdata[7:0];
  end

endmodule

`default_nettype wire

// ==== hdl/axi_lite_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_sram #(
  parameter int sram_words        = 256,
  parameter int sram_read_latency = 2
) (
  input  logic                               clock,
  input  logic                               reset,
  input  logic [31:0]                        araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [axi_pkg::data_width-1:0]     rdata,
  output axi_pkg::resp_t                     rresp,
  output logic                               rvalid,
  input  logic                               rready,
  input  logic [31:0]                        awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [axi_pkg::data_width-1:0]     wdata,
  input  logic [axi_pkg::data_width/8-1:0]   wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  output axi_pkg::resp_t                     bresp,
  output logic                               bvalid,
  input  logic                               bready
);

  import axi_pkg::*;

  localparam int index_width = $clog2(sram_words);
  localparam int count_width = $clog2(sram_read_latency + 1);

  typedef enum logic [2:0] {s_idle, s_read, s_rresp, s_wdata, s_bresp} sram_state_t;

  sram_state_t            state;
  logic [data_width-1:0]  mem [sram_words];
  logic [29:0]            index;
  logic [count_width-1:0] count;
  logic                   in_range;

  assign in_range = index < sram_words;
  assign arready  = (state == s_idle);
  assign awready  = (state == s_idle) && !arvalid;   // reads first.
  assign wready   = (state == s_wdata);

  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= s_idle;
      rvalid <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          if (arvalid) state <= s_read;
          else if (awvalid) state <= s_wdata;
        end
        s_read: begin
          if (count == '0) begin
            rvalid <= 1'b1;
            state  <= s_rresp;
          end
        end
        s_rresp: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= s_idle;
          end
        end
        s_wdata: begin
          if (wvalid) begin
            bvalid <= 1'b1;
            state  <= s_bresp;
          end
        end
        default: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= s_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == s_idle && arvalid) begin
      index <= araddr[31:2];
      count <= count_width'(sram_read_latency - 1);
    end else if (state == s_idle && awvalid) begin
      index <= awaddr[31:2];
    end else if (state == s_read && count != '0) begin
      count <= count - 1'b1;
    end
    if (state == s_read && count == '0) begin
      rdata <= in_range ? mem[index[index_width-1:0]] : '0;
      rresp <= in_range ? resp_okay : resp_slverr;
    end
    if (state == s_wdata && wvalid) begin
      bresp <= in_range ? resp_okay : resp_slverr;
      for (int i = 0; i < data_width / 8; i++) begin
        if (in_range && wstrb[i]) mem[index[index_width-1:0]][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/axi_lite_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_decoder (
  input  logic                               clock,
  input  logic                               reset,
  input  logic [31:0]                        araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [axi_pkg::data_width-1:0]     rdata,
  output axi_pkg::resp_t                     rresp,
  output logic                               rvalid,
  input  logic                               rready,
  input  logic [31:0]                        awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [axi_pkg::data_width-1:0]     wdata,
  input  logic [axi_pkg::data_width/8-1:0]   wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  output axi_pkg::resp_t                     bresp,
  output logic                               bvalid,
  input  logic                               bready,
  output logic [31:0]                        sram_araddr,
  output logic                               sram_arvalid,
  input  logic                               sram_arready,
  input  logic [axi_pkg::data_width-1:0]     sram_rdata,
  input  axi_pkg::resp_t                     sram_rresp,
  input  logic                               sram_rvalid,
  output logic                               sram_rready,
  output logic [31:0]                        sram_awaddr,
  output logic                               sram_awvalid,
  input  logic                               sram_awready,
  output logic [axi_pkg::data_width-1:0]     sram_wdata,
  output logic [axi_pkg::data_width/8-1:0]   sram_wstrb,
  output logic                               sram_wvalid,
  input  logic                               sram_wready,
  input  axi_pkg::resp_t                     sram_bresp,
  input  logic                               sram_bvalid,
  output logic                               sram_bready,
  output logic                               console_arvalid,
  input  logic                               console_arready,
  input  logic [axi_pkg::data_width-1:0]     console_rdata,
  input  axi_pkg::resp_t                     console_rresp,
  input  logic                               console_rvalid,
  output logic                               console_rready,
  output logic                               console_awvalid,
  input  logic                               console_awready,
  output logic [axi_pkg::data_width-1:0]     console_wdata,
  output logic [axi_pkg::data_width/8-1:0]   console_wstrb,
  output logic                               console_wvalid,
  input  logic                               console_wready,
  input  axi_pkg::resp_t                     console_bresp,
  input  logic                               console_bvalid,
  output logic                               console_bready
);

  import axi_pkg::*;

  typedef enum logic [1:0] {tgt_sram, tgt_console, tgt_none} target_t;

  target_t     target;
  target_t     addr_target;
  logic        busy;
  logic        err_rvalid;
  logic        err_bvalid;
  logic        sel_arready;
  logic        sel_awready;
  logic [31:0] req_addr;

  assign req_addr = arvalid ? araddr : awaddr;

  always_comb begin
    if (req_addr[31:28] == sram_base[31:28]) begin
      addr_target = tgt_sram;
    end else if (req_addr[31:12] == console_page) begin
      addr_target = tgt_console;
    end else begin
      addr_target = tgt_none;   // answered here.
    end
  end

  assign sram_araddr     = araddr - sram_base;   // byte offset into the region.
  assign sram_awaddr     = awaddr - sram_base;
  assign sram_arvalid    = !busy && arvalid && addr_target == tgt_sram;
  assign sram_awvalid    = !busy && awvalid && addr_target == tgt_sram;
  assign console_arvalid = !busy && arvalid && addr_target == tgt_console;
  assign console_awvalid = !busy && awvalid && addr_target == tgt_console;

  assign sel_arready = addr_target == tgt_sram    ? sram_arready :
                       addr_target == tgt_console ? console_arready : 1'b1;
  assign sel_awready = addr_target == tgt_sram    ? sram_awready :
                       addr_target == tgt_console ? console_awready : 1'b1;
  assign arready = !busy && arvalid && sel_arready;
  assign awready = !busy && awvalid && sel_awready;

  assign sram_wdata     = wdata;
  assign sram_wstrb     = wstrb;
  assign console_wdata  = wdata;
  assign console_wstrb  = wstrb;
  assign sram_wvalid    = busy && target == tgt_sram && wvalid;
  assign console_wvalid = busy && target == tgt_console && wvalid;
  assign sram_rready    = busy && target == tgt_sram && rready;
  assign console_rready = busy && target == tgt_console && rready;
  assign sram_bready    = busy && target == tgt_sram && bready;
  assign console_bready = busy && target == tgt_console && bready;

  always_comb begin
    rdata = '0;
    rresp = resp_decerr;
    bresp = resp_decerr;
    case (target)
      tgt_sram: begin
        rvalid = sram_rvalid;
        rdata  = sram_rdata;
        rresp  = sram_rresp;
        wready = sram_wready;
        bvalid = sram_bvalid;
        bresp  = sram_bresp;
      end
      tgt_console: begin
        rvalid = console_rvalid;
        rdata  = console_rdata;
        rresp  = console_rresp;
        wready = console_wready;
        bvalid = console_bvalid;
        bresp  = console_bresp;
      end
      default: begin
        rvalid = err_rvalid;
        wready = !err_bvalid;
        bvalid = err_bvalid;
      end
    endcase
    if (!busy) begin
      rvalid = 1'b0;
      wready = 1'b0;
      bvalid = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy       <= 1'b0;
      target     <= tgt_none;
      err_rvalid <= 1'b0;
      err_bvalid <= 1'b0;
    end else if (arvalid && arready || awvalid && awready) begin
      busy       <= 1'b1;
      target     <= addr_target;
      err_rvalid <= arvalid && addr_target == tgt_none;
    end else if (rvalid && rready || bvalid && bready) begin
      busy       <= 1'b0;
      err_rvalid <= 1'b0;
      err_bvalid <= 1'b0;
    end else if (target == tgt_none && wvalid && wready) begin
      err_bvalid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               ren,
  input  logic                               wen,
  input  logic [31:0]                        addr,
  input  lsu_pkg::access_size_t              size,
  input  logic                               sign_extend,
  input  logic [31:0]                        store_data,
  output logic [31:0]                        load_data,
  output logic                               read_done,
  output logic                               write_done,
  output axi_pkg::resp_t                     resp,
  output logic [31:0]                        araddr,
  output logic                               arvalid,
  input  logic                               arready,
  input  logic [axi_pkg::data_width-1:0]     rdata,
  input  axi_pkg::resp_t                     rresp,
  input  logic                               rvalid,
  output logic                               rready,
  output logic [31:0]                        awaddr,
  output logic                               awvalid,
  input  logic                               awready,
  output logic [axi_pkg::data_width-1:0]     wdata,
  output logic [axi_pkg::data_width/8-1:0]   wstrb,
  output logic                               wvalid,
  input  logic                               wready,
  input  axi_pkg::resp_t                     bresp,
  input  logic                               bvalid,
  output logic                               bready
);

  import lsu_pkg::*;

  lsu_state_t  state;
  logic [4:0]  shift;
  logic [3:0]  lanes;
  logic [31:0] load_word;
  logic [31:0] load_value;

  assign shift = {addr[1:0], 3'b000};   // byte offset in bits.

  assign araddr  = addr;
  assign awaddr  = addr;
  assign arvalid = (state == read_addr);
  assign rready  = (state == read_data);
  assign awvalid = (state == write_addr);
  assign wvalid  = (state == write_data);
  assign bready  = (state == write_resp);

  always_comb begin
    case (size)
      size_byte: lanes = 4'b0001;
      size_half: lanes = 4'b0011;
      default:   lanes = 4'b1111;
    endcase
  end

  assign wstrb = lanes << addr[1:0];
  assign wdata = store_data << shift;

  assign load_word = rdata >> shift;

  always_comb begin
    case (size)
      size_byte: load_value = {{24{sign_extend & load_word[7]}}, load_word[7:0]};
      size_half: load_value = {{16{sign_extend & load_word[15]}}, load_word[15:0]};
      default:   load_value = load_word;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= idle;
      read_done  <= 1'b0;
      write_done <= 1'b0;
    end else begin
      read_done  <= 1'b0;
      write_done <= 1'b0;
      case (state)
        idle: begin
          if (wen) begin
            state <= write_addr;   // write wins.
          end else if (ren) begin
            state <= read_addr;
          end
        end
        read_addr:  if (arready) state <= read_data;
        read_data: begin
          if (rvalid) begin
            read_done <= 1'b1;
            state     <= finish;
          end
        end
        write_addr: if (awready) state <= write_data;
        write_data: if (wready) state <= write_resp;
        write_resp: begin
          if (bvalid) begin
            write_done <= 1'b1;
            state      <= finish;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == read_data && rvalid) begin
      load_data <= load_value;
      resp      <= rresp;
    end
    if (state == write_resp && bvalid) begin
      resp <= bresp;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_t;

  typedef enum logic [2:0] {
    idle       = 3'd0,
    read_addr  = 3'd1,
    read_data  = 3'd2,
    write_addr = 3'd3,
    write_data = 3'd4,
    write_resp = 3'd5,
    finish     = 3'd6
  } lsu_state_t;

endpackage

`default_nettype wire

// ==== hdl/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

  localparam int data_width = 32;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_t;

  localparam logic [31:0] sram_base = 32'h8000_0000;   // region is the top nibble.
  localparam logic [19:0] console_page = 20'h1_0000;   // uart page, bits 31:12.

endpackage

`default_nettype wire
